/* loadAlign.sv */
`timescale 1ns/1ps
`default_nettype none

module loadAlign
(
    input  wire logic [5:0]  opcode,
    input  wire logic [1:0]  byteOff,
    input  wire logic [31:0] memWord,
    output      logic [31:0] loadData
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // little endian lanes
    assign byteSel = memWord[byteOff * 8 +: 8];
    assign halfSel = memWord[byteOff[1] * 16 +: 16];

    always_comb
    begin
        case (opcode)
            mipsIsaPkg::opLb:
            begin
                loadData = {{24{byteSel[7]}}, byteSel};
            end
            mipsIsaPkg::opLbu:
            begin
                loadData = {24'd0, byteSel};
            end
            mipsIsaPkg::opLh:
            begin
                loadData = {{16{halfSel[15]}}, halfSel};
            end
            mipsIsaPkg::opLhu:
            begin
                loadData = {16'd0, halfSel};
            end
            default:
            begin
                loadData = memWord;     // lw
            end
        endcase
    end

endmodule

`default_nettype wire

/* memWbReg.sv */
`timescale 1ns/1ps
`default_nettype none

module memWbReg
(
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire wbStagePkg::memWbT memIn,
    output      wbStagePkg::memWbT stage
);

    // bubble on reset, valid low and instr zero
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            stage <= '0;
        end
        else
        begin
            stage <= memIn;
        end
    end

endmodule

`default_nettype wire

/* mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

    ////////////////////////////////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////////////////////////////////
    localparam logic [5:0] opRtype  = 6'b000000;
    localparam logic [5:0] opRegimm = 6'b000001;   // bltz, bgez
    localparam logic [5:0] opJ      = 6'b000010;
    localparam logic [5:0] opJal    = 6'b000011;
    localparam logic [5:0] opBeq    = 6'b000100;
    localparam logic [5:0] opBne    = 6'b000101;
    localparam logic [5:0] opBlez   = 6'b000110;
    localparam logic [5:0] opBgtz   = 6'b000111;
    localparam logic [5:0] opAddi   = 6'b001000;
    localparam logic [5:0] opAddiu  = 6'b001001;
    localparam logic [5:0] opSlti   = 6'b001010;
    localparam logic [5:0] opSltiu  = 6'b001011;
    localparam logic [5:0] opAndi   = 6'b001100;
    localparam logic [5:0] opOri    = 6'b001101;
    localparam logic [5:0] opXori   = 6'b001110;
    localparam logic [5:0] opLui    = 6'b001111;
    localparam logic [5:0] opLb     = 6'b100000;
    localparam logic [5:0] opLh     = 6'b100001;
    localparam logic [5:0] opLw     = 6'b100011;
    localparam logic [5:0] opLbu    = 6'b100100;
    localparam logic [5:0] opLhu    = 6'b100101;
    localparam logic [5:0] opSb     = 6'b101000;
    localparam logic [5:0] opSh     = 6'b101001;
    localparam logic [5:0] opSw     = 6'b101011;

    ////////////////////////////////////////////////////////////////////
    // funct codes for opRtype
    ////////////////////////////////////////////////////////////////////
    localparam logic [5:0] fnSll   = 6'b000000;    // also nop when all zero
    localparam logic [5:0] fnSrl   = 6'b000010;
    localparam logic [5:0] fnSra   = 6'b000011;
    localparam logic [5:0] fnSllv  = 6'b000100;
    localparam logic [5:0] fnSrlv  = 6'b000110;
    localparam logic [5:0] fnSrav  = 6'b000111;
    localparam logic [5:0] fnJr    = 6'b001000;
    localparam logic [5:0] fnJalr  = 6'b001001;
    localparam logic [5:0] fnMfhi  = 6'b010000;
    localparam logic [5:0] fnMthi  = 6'b010001;
    localparam logic [5:0] fnMflo  = 6'b010010;
    localparam logic [5:0] fnMtlo  = 6'b010011;
    localparam logic [5:0] fnMult  = 6'b011000;
    localparam logic [5:0] fnMultu = 6'b011001;
    localparam logic [5:0] fnDiv   = 6'b011010;
    localparam logic [5:0] fnDivu  = 6'b011011;
    localparam logic [5:0] fnAdd   = 6'b100000;
    localparam logic [5:0] fnAddu  = 6'b100001;
    localparam logic [5:0] fnSub   = 6'b100010;
    localparam logic [5:0] fnSubu  = 6'b100011;
    localparam logic [5:0] fnAnd   = 6'b100100;
    localparam logic [5:0] fnOr    = 6'b100101;
    localparam logic [5:0] fnXor   = 6'b100110;
    localparam logic [5:0] fnNor   = 6'b100111;
    localparam logic [5:0] fnSlt   = 6'b101010;
    localparam logic [5:0] fnSltu  = 6'b101011;

    localparam int         numRegs = 32;
    localparam logic [4:0] regRa   = 5'd31;        // link register

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmtT;

    // same word, two field layouts
    typedef union packed {
        rFmtT        r;
        iFmtT        i;
        logic [31:0] raw;
    } instrT;

endpackage

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile
(
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire wbStagePkg::regWriteT wr,
    input  wire logic [4:0]           rsAddr,
    input  wire logic [4:0]           rtAddr,
    output      logic [31:0]          rsData,
    output      logic [31:0]          rtData
);

    logic [31:0] regs [mipsIsaPkg::numRegs];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int k = 0; k < mipsIsaPkg::numRegs; k++)
            begin
                regs[k] <= '0;
            end
        end
        else if (wr.we && (wr.addr != 5'd0))
        begin
            regs[wr.addr] <= wr.data;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // reads with same-cycle bypass
    ////////////////////////////////////////////////////////////////////
    assign rsData = (rsAddr == 5'd0)                 ? 32'd0   :
                    (wr.we && (wr.addr == rsAddr))   ? wr.data :
                                                       regs[rsAddr];

    assign rtData = (rtAddr == 5'd0)                 ? 32'd0   :
                    (wr.we && (wr.addr == rtAddr))   ? wr.data :
                                                       regs[rtAddr];

endmodule

`default_nettype wire

/* tb.f */
mipsIsaPkg.sv
wbStagePkg.sv
memWbReg.sv
wbDecode.sv
loadAlign.sv
regFile.sv
writeBackTop.sv
tbWriteBack.sv

/* tbWriteBack.sv */
`timescale 1ns/1ps
`default_nettype none

module tbWriteBack;

    localparam int numInstrs = 400;
    localparam int maxCycles = 600;     // 16 reset + 32 sweep + 40 loads + 400 + drain fits
    localparam int listW     = 108;

    ////////////////////////////////////////////////////////////////////
    // instruction class code lists of six bits per entry
    ////////////////////////////////////////////////////////////////////
    localparam logic [18*6-1:0] aluFnList = {mipsIsaPkg::fnSll, mipsIsaPkg::fnSrl,
        mipsIsaPkg::fnSra, mipsIsaPkg::fnSllv, mipsIsaPkg::fnSrlv, mipsIsaPkg::fnSrav,
        mipsIsaPkg::fnMfhi, mipsIsaPkg::fnMflo, mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu,
        mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu, mipsIsaPkg::fnAnd, mipsIsaPkg::fnOr,
        mipsIsaPkg::fnXor, mipsIsaPkg::fnNor, mipsIsaPkg::fnSlt, mipsIsaPkg::fnSltu};
    localparam logic [7*6-1:0] quietFnList = {mipsIsaPkg::fnJr, mipsIsaPkg::fnMthi,
        mipsIsaPkg::fnMtlo, mipsIsaPkg::fnMult, mipsIsaPkg::fnMultu, mipsIsaPkg::fnDiv,
        mipsIsaPkg::fnDivu};
    localparam logic [8*6-1:0] immOpList = {mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu,
        mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu, mipsIsaPkg::opAndi, mipsIsaPkg::opOri,
        mipsIsaPkg::opXori, mipsIsaPkg::opLui};
    localparam logic [5*6-1:0] loadOpList = {mipsIsaPkg::opLb, mipsIsaPkg::opLh,
        mipsIsaPkg::opLw, mipsIsaPkg::opLbu, mipsIsaPkg::opLhu};
    localparam logic [9*6-1:0] quietOpList = {mipsIsaPkg::opRegimm, mipsIsaPkg::opJ,
        mipsIsaPkg::opBeq, mipsIsaPkg::opBne, mipsIsaPkg::opBlez, mipsIsaPkg::opBgtz,
        mipsIsaPkg::opSb, mipsIsaPkg::opSh, mipsIsaPkg::opSw};

    logic                 clk;
    logic                 rstN;
    wbStagePkg::memWbT    memIn;
    logic [4:0]           rsAddr;
    logic [4:0]           rtAddr;
    logic [31:0]          rsData;
    logic [31:0]          rtData;
    wbStagePkg::regWriteT wbOut;

    wbStagePkg::memWbT    stageModel;
    wbStagePkg::regWriteT expWb;
    logic [31:0]          expRs;
    logic [31:0]          expRt;
    logic [31:0]          shadowRegs [32];
    int                   cycleCount = 0;

    writeBackTop writeBackTop_i (.clk(clk), .rstN(rstN), .memIn(memIn), .rsAddr(rsAddr),
        .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData), .wbOut(wbOut));

    function automatic logic [5:0] pickCode(input logic [listW-1:0] list, input int n);
        return list[($urandom % n) * 6 +: 6];
    endfunction

    function automatic logic inList(input logic [listW-1:0] list, input int n,
                                    input logic [5:0] code);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < n; k++)
        begin
            if (list[k * 6 +: 6] == code)
                hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic mipsIsaPkg::instrT makeInstr(input int cls);
        mipsIsaPkg::instrT ins;
        ins.raw = $urandom;
        case (cls)
            0: ins.r.funct = pickCode(aluFnList, 18);
            1: ins.i.op = pickCode(immOpList, 8);
            2: ins.i.op = pickCode(loadOpList, 5);
            3: ins.i.op = mipsIsaPkg::opJal;
            4: ins.r.funct = mipsIsaPkg::fnJalr;
            5: ins.r.funct = pickCode(quietFnList, 7);
            6: ins.i.op = pickCode(quietOpList, 9);
            default: ins.raw = 32'd0;           // nop
        endcase
        if (cls == 0 || cls == 4 || cls == 5)
            ins.r.op = mipsIsaPkg::opRtype;
        return ins;
    endfunction

    // expected register write for one stage content
    function automatic wbStagePkg::regWriteT predictWrite(input wbStagePkg::memWbT s);
        wbStagePkg::regWriteT w;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] byteLane;
        logic [31:0] halfLane;
        op       = s.instr.raw[31:26];
        fn       = s.instr.raw[5:0];
        byteLane = s.memWord >> (8 * s.aluResult[1:0]);
        halfLane = s.memWord >> (16 * s.aluResult[1]);
        w.we     = 1'b0;
        w.addr   = s.instr.raw[20:16];
        w.data   = s.aluResult;
        if (op == mipsIsaPkg::opRtype)
        begin
            w.addr = s.instr.raw[15:11];
            w.we   = (s.instr.raw != 32'd0) &&
                     (inList(aluFnList, 18, fn) || fn == mipsIsaPkg::fnJalr);
            if (fn == mipsIsaPkg::fnJalr)
                w.data = s.pcPlus8;
        end
        else if (inList(immOpList, 8, op))
        begin
            w.we = 1'b1;
        end
        else if (inList(loadOpList, 5, op))
        begin
            w.we = 1'b1;
            case (op)
                mipsIsaPkg::opLb:  w.data = {{24{byteLane[7]}}, byteLane[7:0]};
                mipsIsaPkg::opLbu: w.data = {24'd0, byteLane[7:0]};
                mipsIsaPkg::opLh:  w.data = {{16{halfLane[15]}}, halfLane[15:0]};
                mipsIsaPkg::opLhu: w.data = {16'd0, halfLane[15:0]};
                default:           w.data = s.memWord;
            endcase
        end
        else if (op == mipsIsaPkg::opJal)
        begin
            w.we   = 1'b1;
            w.addr = 5'd31;
            w.data = s.pcPlus8;
        end
        w.we = w.we && s.valid && (w.addr != 5'd0);
        return w;
    endfunction

    task automatic failValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        $display("error %s got %h expected %h", name, got, exp);
        $display("TB FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    ////////////////////////////////////////////////////////////////////
    // shadow model
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            stageModel <= '0;
            for (int k = 0; k < 32; k++)
                shadowRegs[k] <= '0;
        end
        else
        begin
            stageModel <= memIn;
            if (expWb.we)
                shadowRegs[expWb.addr] <= expWb.data;
        end
    end

    always_comb
    begin
        expWb = predictWrite(stageModel);
        if (rsAddr == 5'd0)
            expRs = '0;
        else if (expWb.we && expWb.addr == rsAddr)
            expRs = expWb.data;                 // bypass
        else
            expRs = shadowRegs[rsAddr];
        if (rtAddr == 5'd0)
            expRt = '0;
        else if (expWb.we && expWb.addr == rtAddr)
            expRt = expWb.data;
        else
            expRt = shadowRegs[rtAddr];
    end

    weCheck: assert property (@(posedge clk) disable iff (!rstN) wbOut.we == expWb.we)
        else failValue("wbOut.we", $sampled(wbOut.we), $sampled(expWb.we));
    addrCheck: assert property (@(posedge clk) disable iff (!rstN)
            expWb.we |-> wbOut.addr == expWb.addr)
        else failValue("wbOut.addr", $sampled(wbOut.addr), $sampled(expWb.addr));
    dataCheck: assert property (@(posedge clk) disable iff (!rstN)
            expWb.we |-> wbOut.data == expWb.data)
        else failValue("wbOut.data", $sampled(wbOut.data), $sampled(expWb.data));
    rsCheck: assert property (@(posedge clk) disable iff (!rstN) rsData == expRs)
        else failValue("rsData", $sampled(rsData), $sampled(expRs));
    rtCheck: assert property (@(posedge clk) disable iff (!rstN) rtData == expRt)
        else failValue("rtData", $sampled(rtData), $sampled(expRt));

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles)
        begin
            $display("timeout, the run did not finish within %0d cycles", maxCycles);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        wbStagePkg::memWbT nextIn;
        mipsIsaPkg::instrT prevInstr;
        int                cls;
        void'($urandom(8));
        rstN      = 1'b0;
        memIn     = '0;
        rsAddr    = '0;
        rtAddr    = '0;
        prevInstr = '0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        for (int k = 0; k < 32; k++)            // every address reads zero
        begin
            @(posedge clk);
            rsAddr <= 5'(k);
            rtAddr <= 5'(31 - k);
        end
        for (int k = 0; k < 40; k++)            // every load and offset with both signs
        begin
            @(posedge clk);
            nextIn            = '0;
            nextIn.valid      = 1'b1;
            nextIn.instr.raw  = $urandom;
            nextIn.instr.i.op = loadOpList[(k % 5) * 6 +: 6];
            nextIn.pcPlus8    = $urandom;
            nextIn.aluResult  = {30'($urandom), 2'(k / 5)};
            nextIn.memWord    = (k < 20) ? ($urandom | 32'h80808080) :
                                           ($urandom & 32'h7f7f7f7f);
            memIn  <= nextIn;
            rsAddr <= prevInstr.raw[20:16];
            rtAddr <= 5'($urandom);
            prevInstr = nextIn.instr;
        end
        for (int n = 0; n < numInstrs; n++)
        begin
            @(posedge clk);
            cls              = $urandom % 9;
            nextIn.valid     = (cls != 8);      // class 8 is an invalid cycle
            nextIn.instr     = makeInstr((cls == 8) ? ($urandom % 8) : cls);
            nextIn.pcPlus8   = $urandom;
            nextIn.aluResult = $urandom;
            nextIn.memWord   = $urandom;
            memIn  <= nextIn;
            rsAddr <= ($urandom % 2) ? prevInstr.raw[15:11] : prevInstr.raw[20:16];
            rtAddr <= 5'($urandom);
            prevInstr = nextIn.instr;
        end
        @(posedge clk);
        memIn <= '0;
        repeat (3) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* wbDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module wbDecode
(
    input  wire wbStagePkg::memWbT stage,
    output      logic              wrEn,
    output      logic [4:0]        wrAddr,
    output      logic [1:0]        wbSrc
);

    logic       writes;
    logic [4:0] dst;

    always_comb
    begin
        writes = 1'b0;
        wbSrc  = wbStagePkg::wbSrcAlu;
        dst    = stage.instr.i.rt;                  // i-format default

        case (stage.instr.i.op)
            mipsIsaPkg::opRtype:
            begin
                dst = stage.instr.r.rd;
                case (stage.instr.r.funct)
                    mipsIsaPkg::fnSll:
                    begin
                        writes = (stage.instr.raw != 32'd0);   // all zero is nop
                    end
                    mipsIsaPkg::fnSrl, mipsIsaPkg::fnSra,
                    mipsIsaPkg::fnSllv, mipsIsaPkg::fnSrlv, mipsIsaPkg::fnSrav,
                    mipsIsaPkg::fnMfhi, mipsIsaPkg::fnMflo,
                    mipsIsaPkg::fnAdd, mipsIsaPkg::fnAddu,
                    mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu,
                    mipsIsaPkg::fnAnd, mipsIsaPkg::fnOr,
                    mipsIsaPkg::fnXor, mipsIsaPkg::fnNor,
                    mipsIsaPkg::fnSlt, mipsIsaPkg::fnSltu:
                    begin
                        writes = 1'b1;
                    end
                    mipsIsaPkg::fnJalr:
                    begin
                        writes = 1'b1;
                        wbSrc  = wbStagePkg::wbSrcLink;
                    end
                    default:
                    begin
                        writes = 1'b0;                  // jr, mthi/mtlo, mult/div
                    end
                endcase
            end

            mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu,
            mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu,
            mipsIsaPkg::opAndi, mipsIsaPkg::opOri,
            mipsIsaPkg::opXori, mipsIsaPkg::opLui:
            begin
                writes = 1'b1;
            end

            mipsIsaPkg::opLb, mipsIsaPkg::opLh, mipsIsaPkg::opLw,
            mipsIsaPkg::opLbu, mipsIsaPkg::opLhu:
            begin
                writes = 1'b1;
                wbSrc  = wbStagePkg::wbSrcMem;
            end

            mipsIsaPkg::opJal:
            begin
                writes = 1'b1;
                wbSrc  = wbStagePkg::wbSrcLink;
                dst    = mipsIsaPkg::regRa;
            end

            default:
            begin
                writes = 1'b0;                          // branches, stores, j
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////
    assign wrAddr = dst;
    assign wrEn   = stage.valid && writes && (dst != 5'd0);

endmodule

`default_nettype wire

/* wbStagePkg.sv */
`default_nettype none

package wbStagePkg;

    ////////////////////////////////////////////////////////////////////
    // write-back source select
    ////////////////////////////////////////////////////////////////////
    localparam logic [1:0] wbSrcAlu  = 2'd0;
    localparam logic [1:0] wbSrcMem  = 2'd1;   // aligned load data
    localparam logic [1:0] wbSrcLink = 2'd2;   // pc + 8

    ////////////////////////////////////////////////////////////////////
    // pipeline payloads
    ////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                valid;
        mipsIsaPkg::instrT   instr;
        logic [31:0]         pcPlus8;
        logic [31:0]         aluResult;   // also carries hi/lo for mfhi/mflo
        logic [31:0]         memWord;     // raw word from data memory
    } memWbT;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } regWriteT;

endpackage

`default_nettype wire

/* writeBackTop.sv */
`timescale 1ns/1ps
`default_nettype none

module writeBackTop
(
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire wbStagePkg::memWbT    memIn,
    input  wire logic [4:0]           rsAddr,
    input  wire logic [4:0]           rtAddr,
    output      logic [31:0]          rsData,
    output      logic [31:0]          rtData,
    output      wbStagePkg::regWriteT wbOut
);

    wbStagePkg::memWbT stage;
    logic              wrEn;
    logic [4:0]        wrAddr;
    logic [1:0]        wbSrc;
    logic [31:0]       loadData;

    memWbReg memWbReg_i (.clk(clk), .rstN(rstN), .memIn(memIn), .stage(stage));

    wbDecode wbDecode_i (.stage(stage), .wrEn(wrEn), .wrAddr(wrAddr), .wbSrc(wbSrc));

    loadAlign loadAlign_i
    (
        .opcode   (stage.instr.i.op),
        .byteOff  (stage.aluResult[1:0]),   // address low bits
        .memWord  (stage.memWord),
        .loadData (loadData)
    );

    ////////////////////////////////////////////////////////////////////
    // write-back data select
    ////////////////////////////////////////////////////////////////////
    always_comb
    begin
        wbOut.we   = wrEn;
        wbOut.addr = wrAddr;
        case (wbSrc)
            wbStagePkg::wbSrcMem:  wbOut.data = loadData;
            wbStagePkg::wbSrcLink: wbOut.data = stage.pcPlus8;
            default:               wbOut.data = stage.aluResult;
        endcase
    end

    regFile regFile_i
    (
        .clk    (clk),
        .rstN   (rstN),
        .wr     (wbOut),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData)
    );

endmodule

`default_nettype wire
